/* Makefile */
# Verilator flow for the processing node
# Override any variable on the command line, e.g. make BUILD_DIR=build

VERILATOR   ?= verilator
FLIST       ?= flist.f
TB_TOP      ?= tb_node_top
RTL_TOP     ?= node_top
BUILD_DIR   ?= obj_dir
BUILD_FLAGS ?= --binary -j 0
LINT_FLAGS  ?= -Wall --timing

SOURCES := $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(BUILD_FLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# Exit status of the simulation is the test result
run: build
	./$(BUILD_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* flist.f */
+incdir+verilog
verilog/node_pkg.sv
verilog/node_ram.sv
verilog/node_core.sv
verilog/node_top.sv
testbench/tb_node_top.sv

/* testbench/tb_node_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "node_defines.svh"

module tb_node_top;

localparam int INST_DEPTH   = 1 << `NODE_INST_ADDR_W;
localparam int DATA_DEPTH   = 1 << `NODE_DATA_ADDR_W;
localparam int MIX_LENGTH   = 48;
localparam int IDLE_TIMEOUT = 4000;
localparam int QUIET_CYCLES = 50;

// ==============================
// DUT signals
// ==============================

logic                         clk = 1'b0;
logic                         reset;
logic                         trigger;
logic                         load_valid;
logic [`NODE_INST_ADDR_W-1:0] load_addr;
node_pkg::instruction_t       load_data;
logic                         send_ready;
logic                         idle;
node_pkg::node_message_t      send_data;
logic                         send_valid;

integer seed = 32'he12f;

// Programs, model state, expected messages
node_pkg::instruction_t  program_mem [2][INST_DEPTH];
int                      program_len [2];
logic [3:0]              pool_hi [2];
logic [7:0]              model_reg [`NODE_REG_COUNT];
logic [7:0]              model_mem [DATA_DEPTH];
node_pkg::node_message_t expected_q [$];
int                      message_count;
int                      program_no;

initial begin : clock_gen
    forever begin
        #10 clk = ~clk;
    end
end

node_top dut (
    .i_clk        (clk),
    .i_reset      (reset),
    .i_trigger    (trigger),
    .o_idle       (idle),
    .i_load_valid (load_valid),
    .i_load_addr  (load_addr),
    .i_load_data  (load_data),
    .o_send_data  (send_data),
    .o_send_valid (send_valid),
    .i_send_ready (send_ready)
);

// ==============================
// Checks
// ==============================

task automatic abort_run(input string what);
    $display("=== FAIL ===");
    $fatal(1, "%s", what);
endtask

task automatic check_message(input string name, input node_pkg::node_message_t expected,
                             input node_pkg::node_message_t actual);
    if (actual !== expected) begin
        $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        abort_run("outbound message differs from the model");
    end
endtask

task automatic check_idle(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("FAILED %s: expected %b, actual %b", name, expected, actual);
        abort_run("o_idle differs from the expected state");
    end
endtask

// ==============================
// Program generation
// ==============================

// Random fields with the opcode forced on top
function automatic node_pkg::instruction_t with_opcode(input logic [31:0] bits,
                                                       input node_pkg::opcode_t op);
    node_pkg::instruction_t w;
    w = bits;
    w.pause.op = op;
    return w;
endfunction

// Register and send target stay random
function automatic node_pkg::instruction_t memory_word(input logic [31:0] bits,
                                                       input node_pkg::mem_mode_t mode,
                                                       input logic [7:0] addr);
    node_pkg::instruction_t w;
    w = with_opcode(bits, node_pkg::OP_MEMORY);
    w.memory.mode    = mode;
    w.memory.address = addr;
    return w;
endfunction

task automatic emit(input int p, input node_pkg::instruction_t w);
    program_mem[p][program_len[p]] = w;
    program_len[p]++;
endtask

task automatic build_program(input int p);
    logic [31:0]            bits;
    logic [31:0]            pick_bits;
    int                     choice;
    node_pkg::instruction_t w;
    node_pkg::instruction_t halt;
    program_len[p] = 0;
    bits = $random(seed);
    // Each program works on its own 16-byte pool
    pool_hi[p] = bits[3:0];
    // Seed R7 through the lookup table
    for (int i = 0; i < 8; i++) begin
        bits = $random(seed);
        emit(p, with_opcode(bits, node_pkg::OP_TRUTH));
    end
    // Spread R7 into R0 to R6 with random permutations
    for (int r = 0; r < 7; r++) begin
        bits = $random(seed);
        w = with_opcode(bits, node_pkg::OP_SHUFFLE);
        w.shuffle.src = node_pkg::reg_idx_t'(`NODE_REG_COUNT - 1);
        w.shuffle.tgt = node_pkg::reg_idx_t'(r);
        emit(p, w);
    end
    // Whole pool written before any load
    for (int a = 0; a < 16; a++) begin
        bits = $random(seed);
        emit(p, memory_word(bits, node_pkg::MEM_STORE, {pool_hi[p], a[3:0]}));
    end
    for (int i = 0; i < 4; i++) begin
        bits = $random(seed);
        emit(p, memory_word(bits, node_pkg::MEM_LOAD, {pool_hi[p], bits[31:28]}));
    end
    // Random mix
    for (int i = 0; i < MIX_LENGTH; i++) begin
        bits      = $random(seed);
        pick_bits = $random(seed);
        choice    = int'(pick_bits[7:0]) % 5;
        case (choice)
            0: emit(p, with_opcode(bits, node_pkg::OP_TRUTH));
            1: emit(p, with_opcode(bits, node_pkg::OP_SHUFFLE));
            2: emit(p, memory_word(bits, node_pkg::MEM_STORE, {pool_hi[p], bits[31:28]}));
            3: emit(p, memory_word(bits, node_pkg::MEM_LOAD, {pool_hi[p], bits[31:28]}));
            default: emit(p, memory_word(bits, node_pkg::MEM_SEND, bits[31:24]));
        endcase
    end
    // Dump of all registers
    for (int r = 0; r < `NODE_REG_COUNT; r++) begin
        bits = $random(seed);
        w = memory_word(bits, node_pkg::MEM_SEND, bits[31:24]);
        w.memory.reg_sel = node_pkg::reg_idx_t'(r);
        emit(p, w);
    end
    halt = '0;
    halt.pause.op   = node_pkg::OP_PAUSE;
    halt.pause.idle = 1'b1;
    halt.pause.pc0  = 1'b1;
    emit(p, halt);
    // Rest of the store filled with PAUSE words tagged by their address
    for (int a = program_len[p]; a < INST_DEPTH; a++) begin
        w = halt;
        w.pause.padding[`NODE_INST_ADDR_W-1:0] = a[`NODE_INST_ADDR_W-1:0];
        program_mem[p][a] = w;
    end
endtask

// ==============================
// Instruction-set model
// ==============================

// One instruction at a time in program order
task automatic run_model(input int p);
    node_pkg::instruction_t  w;
    logic [2:0]              index;
    logic [7:0]              source;
    logic [7:0]              shuffled;
    logic [2:0]              sel [8];
    node_pkg::node_message_t msg;
    bit                      halted;
    halted = 1'b0;
    for (int i = 0; i < program_len[p] && !halted; i++) begin
        w = program_mem[p][i];
        case (w.pause.op)
            node_pkg::OP_PAUSE: begin
                halted = 1'b1;
            end
            node_pkg::OP_TRUTH: begin
                // Source A gives the low index bit
                index = {model_reg[w.truth.src_c][w.truth.mux_2],
                         model_reg[w.truth.src_b][w.truth.mux_1],
                         model_reg[w.truth.src_a][w.truth.mux_0]};
                model_reg[`NODE_REG_COUNT-1] = {model_reg[`NODE_REG_COUNT-1][6:0],
                                                w.truth.lut[index]};
            end
            node_pkg::OP_SHUFFLE: begin
                sel = '{w.shuffle.mux_0, w.shuffle.mux_1, w.shuffle.mux_2, w.shuffle.mux_3,
                        w.shuffle.mux_4, w.shuffle.mux_5, w.shuffle.mux_6, w.shuffle.mux_7};
                source = model_reg[w.shuffle.src];
                for (int b = 0; b < 8; b++) begin
                    shuffled[b] = source[sel[b]];
                end
                model_reg[w.shuffle.tgt] = shuffled;
            end
            default: begin
                case (w.memory.mode)
                    node_pkg::MEM_LOAD: begin
                        model_reg[w.memory.reg_sel] = model_mem[w.memory.address];
                    end
                    node_pkg::MEM_STORE: begin
                        model_mem[w.memory.address] = model_reg[w.memory.reg_sel];
                    end
                    default: begin
                        msg.target  = w.memory.send_tgt;
                        msg.address = w.memory.address;
                        msg.data    = model_reg[w.memory.reg_sel];
                        expected_q.push_back(msg);
                    end
                endcase
            end
        endcase
    end
endtask

// ==============================
// Stimulus
// ==============================

task automatic load_program(input int p);
    for (int a = 0; a < INST_DEPTH; a++) begin
        @(negedge clk);
        load_valid = 1'b1;
        load_addr  = a[`NODE_INST_ADDR_W-1:0];
        load_data  = program_mem[p][a];
    end
    @(negedge clk);
    load_valid = 1'b0;
endtask

task automatic run_program(input int p);
    int cycles;
    program_no    = p;
    message_count = 0;
    check_idle($sformatf("program %0d idle before load", p), 1'b1, idle);
    load_program(p);
    run_model(p);
    @(negedge clk);
    trigger = 1'b1;
    @(negedge clk);
    trigger = 1'b0;
    check_idle($sformatf("program %0d idle cleared by trigger", p), 1'b0, idle);
    // Run length depends on back-pressure
    cycles = 0;
    while (idle !== 1'b1 && cycles < IDLE_TIMEOUT) begin
        @(negedge clk);
        cycles++;
    end
    if (idle !== 1'b1) begin
        abort_run($sformatf("program %0d never returned to idle", p));
    end else if (expected_q.size() != 0) begin
        abort_run($sformatf("program %0d stopped with %0d messages never sent",
                            p, expected_q.size()));
    end else begin
        $display("program %0d: %0d messages checked in %0d cycles", p, message_count, cycles);
        // Node must stay quiet after the final PAUSE
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            check_idle($sformatf("program %0d idle after pause", p), 1'b1, idle);
        end
    end
endtask

// Random back-pressure and message checks
initial begin : send_monitor
    logic                    held;
    logic [31:0]             ready_bits;
    node_pkg::node_message_t held_data;
    node_pkg::node_message_t expected;
    send_ready = 1'b0;
    held       = 1'b0;
    held_data  = '0;
    forever begin
        @(negedge clk);
        // Stalled message must not move
        if (held) begin
            if (send_valid !== 1'b1) begin
                abort_run("o_send_valid dropped before the message was accepted");
            end else begin
                check_message($sformatf("program %0d held message %0d",
                                        program_no, message_count), held_data, send_data);
            end
        end
        ready_bits = $random(seed);
        send_ready = (ready_bits[1:0] != 2'b00);
        held       = 1'b0;
        if (send_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                abort_run("message sent when the model expects none");
            end else if (send_ready) begin
                // Taken on the coming rising edge
                expected = expected_q.pop_front();
                check_message($sformatf("program %0d message %0d", program_no, message_count),
                              expected, send_data);
                message_count++;
            end else begin
                held      = 1'b1;
                held_data = send_data;
            end
        end
    end
end

initial begin : main_flow
    reset         = 1'b1;
    trigger       = 1'b0;
    load_valid    = 1'b0;
    load_addr     = '0;
    load_data     = '0;
    message_count = 0;
    program_no    = 0;
    for (int r = 0; r < `NODE_REG_COUNT; r++) begin
        model_reg[r] = '0;
    end
    build_program(0);
    build_program(1);
    repeat (16) @(negedge clk);
    reset = 1'b0;
    check_idle("idle after reset", 1'b1, idle);
    if (send_valid !== 1'b0) begin
        $display("FAILED send_valid after reset: expected 0, actual %b", send_valid);
        abort_run("o_send_valid high after reset");
    end else begin
        // Any message here is caught by the monitor
        repeat (20) @(negedge clk);
        // Second run restarts at zero with carried-over state
        for (int p = 0; p < 2; p++) begin
            run_program(p);
        end
        $display("=== PASS ===");
        $finish;
    end
end

endmodule

`default_nettype wire

/* verilog/node_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "node_defines.svh"

module node_core (
    input  wire                          i_clk,
    input  wire                          i_reset,
    // Control
    input  wire                          i_trigger,
    output logic                         o_idle,
    // Instruction RAM
    output logic [`NODE_INST_ADDR_W-1:0] o_inst_addr,
    output logic                         o_inst_rd_en,
    input  wire node_pkg::instruction_t  i_inst_rd_data,
    // Data RAM
    output logic [`NODE_DATA_ADDR_W-1:0] o_data_addr,
    output logic                         o_data_rd_en,
    output logic                         o_data_wr_en,
    output logic [7:0]                   o_data_wr_data,
    input  wire [7:0]                    i_data_rd_data,
    // Outbound messages
    output node_pkg::node_message_t      o_send_data,
    output logic                         o_send_valid,
    input  wire                          i_send_ready
);

// Operand slots A, B, C and the accumulator
localparam int OPND_N = 4;
localparam int OPND_7 = 3;
localparam node_pkg::reg_idx_t ACC_IDX = node_pkg::reg_idx_t'(`NODE_REG_COUNT - 1);

// ==============================
// Signals
// ==============================

logic [7:0]                   regfile_q [`NODE_REG_COUNT];
logic                         pause_q;
logic                         idle_q;
logic                         pc0_q;
logic [`NODE_INST_ADDR_W-1:0] fetch_pc_q;
logic                         fetch_valid_q;
logic                         send_block;
logic                         stall;

// Decode
node_pkg::opcode_t                  dcd_op;
logic                               dcd_valid;
node_pkg::reg_idx_t [OPND_N-1:0]    dcd_src;
node_pkg::reg_idx_t                 dcd_tgt;
logic [OPND_N-1:0][7:0]             dcd_val;
logic [OPND_N-1:0]                  dcd_ovr;
logic [OPND_N-1:0]                  dcd_fwd;
node_pkg::instruction_t             dcd_instr_q;
logic                               dcd_is_pause_q;
logic                               dcd_is_truth_q;
logic                               dcd_is_shuffle_q;
logic                               dcd_is_load_q;
logic                               dcd_is_store_q;
logic                               dcd_is_send_q;
node_pkg::reg_idx_t                 dcd_tgt_q;
logic [OPND_N-1:0][7:0]             dcd_val_q;
logic [OPND_N-1:0]                  dcd_ovr_q;
logic [OPND_N-1:0]                  dcd_fwd_q;

// Execute
logic [OPND_N-1:0][7:0]   exe_val;
logic                     exe_pause;
logic [2:0]               exe_truth_sel;
logic [7:0]               exe_result_truth;
logic [7:0]               exe_result_shuffle;
logic [7:0]               exe_result;
node_pkg::node_message_t  exe_message;

// Commit
node_pkg::reg_idx_t       exe_tgt_q;
logic                     exe_cmt_ld_q;
logic                     exe_cmt_res_q;
logic [7:0]               exe_result_q;
logic                     cmt_valid;
logic [7:0]               cmt_value;
node_pkg::node_message_t  send_data_q;
logic                     send_valid_q;

// ==============================
// Fetch and flow control
// ==============================

// Held message blocks everything behind it
assign send_block = send_valid_q && !i_send_ready;
assign stall      = pause_q || send_block;

// PAUSE acts only when execute advances
assign exe_pause = dcd_is_pause_q && !send_block;

// While blocked re-read the word sitting in decode
always_comb begin : comb_fetch_addr
    if (send_block) begin
        o_inst_addr = fetch_pc_q - 1'b1;
    end else begin
        o_inst_addr = fetch_pc_q;
    end
end

assign o_inst_rd_en = !pause_q;
assign o_idle       = idle_q;

always_ff @(posedge i_clk) begin : ff_fetch
    if (i_reset) begin
        pause_q       <= 1'b1;
        idle_q        <= 1'b1;
        pc0_q         <= 1'b0;
        fetch_pc_q    <= '0;
        fetch_valid_q <= 1'b0;
    end else if (pause_q) begin
        fetch_valid_q <= 1'b0;
        // Release on trigger
        if (i_trigger) begin
            pause_q <= 1'b0;
            idle_q  <= 1'b0;
            pc0_q   <= 1'b0;
            if (pc0_q) begin
                fetch_pc_q <= '0;
            end
        end
    end else if (exe_pause) begin
        pause_q       <= 1'b1;
        idle_q        <= dcd_instr_q.pause.idle;
        pc0_q         <= dcd_instr_q.pause.pc0;
        // Two words in flight behind PAUSE
        // Resume right after it
        fetch_pc_q    <= fetch_pc_q - 1'b1;
        fetch_valid_q <= 1'b0;
    end else if (!send_block) begin
        fetch_pc_q    <= fetch_pc_q + 1'b1;
        fetch_valid_q <= 1'b1;
    end
end

// ==============================
// Decode
// ==============================

// Squash the word fetched behind a PAUSE
assign dcd_op    = i_inst_rd_data.pause.op;
assign dcd_valid = fetch_valid_q && !dcd_is_pause_q;

always_comb begin : comb_dcd_index
    // SHUFFLE src shares the bits of TRUTH src_a
    case (dcd_op)
        node_pkg::OP_MEMORY: dcd_src[0] = i_inst_rd_data.memory.reg_sel;
        default:             dcd_src[0] = i_inst_rd_data.truth.src_a;
    endcase
    dcd_src[1]      = i_inst_rd_data.truth.src_b;
    dcd_src[2]      = i_inst_rd_data.truth.src_c;
    dcd_src[OPND_7] = ACC_IDX;
    // TRUTH always lands in R7
    case (dcd_op)
        node_pkg::OP_TRUTH:   dcd_tgt = ACC_IDX;
        node_pkg::OP_SHUFFLE: dcd_tgt = i_inst_rd_data.shuffle.tgt;
        default:              dcd_tgt = i_inst_rd_data.memory.reg_sel;
    endcase
end

// Commit value forwarded here
// Younger producers flagged for execute
assign cmt_valid = exe_cmt_ld_q || exe_cmt_res_q;
assign cmt_value = exe_cmt_ld_q ? i_data_rd_data : exe_result_q;

always_comb begin : comb_dcd_operands
    for (int i = 0; i < OPND_N; i++) begin
        if (cmt_valid && (exe_tgt_q == dcd_src[i])) begin
            dcd_val[i] = cmt_value;
        end else begin
            dcd_val[i] = regfile_q[dcd_src[i]];
        end
        // Load in execute returns data next cycle
        dcd_ovr[i] = dcd_is_load_q && (dcd_tgt_q == dcd_src[i]);
        // TRUTH or SHUFFLE in execute
        dcd_fwd[i] = (dcd_is_truth_q || dcd_is_shuffle_q) && (dcd_tgt_q == dcd_src[i]);
    end
end

always_ff @(posedge i_clk) begin : ff_decode_ctrl
    if (i_reset) begin
        dcd_is_pause_q   <= 1'b0;
        dcd_is_truth_q   <= 1'b0;
        dcd_is_shuffle_q <= 1'b0;
        dcd_is_load_q    <= 1'b0;
        dcd_is_store_q   <= 1'b0;
        dcd_is_send_q    <= 1'b0;
    end else if (!stall) begin
        dcd_is_pause_q   <= dcd_valid && (dcd_op == node_pkg::OP_PAUSE);
        dcd_is_truth_q   <= dcd_valid && (dcd_op == node_pkg::OP_TRUTH);
        dcd_is_shuffle_q <= dcd_valid && (dcd_op == node_pkg::OP_SHUFFLE);
        dcd_is_load_q    <= dcd_valid && (dcd_op == node_pkg::OP_MEMORY) &&
                            (i_inst_rd_data.memory.mode == node_pkg::MEM_LOAD);
        dcd_is_store_q   <= dcd_valid && (dcd_op == node_pkg::OP_MEMORY) &&
                            (i_inst_rd_data.memory.mode == node_pkg::MEM_STORE);
        dcd_is_send_q    <= dcd_valid && (dcd_op == node_pkg::OP_MEMORY) &&
                            (i_inst_rd_data.memory.mode == node_pkg::MEM_SEND);
    end
end

always_ff @(posedge i_clk) begin : ff_decode_data
    if (!stall) begin
        dcd_instr_q <= i_inst_rd_data;
        dcd_tgt_q   <= dcd_tgt;
        dcd_val_q   <= dcd_val;
        dcd_ovr_q   <= dcd_ovr;
        dcd_fwd_q   <= dcd_fwd;
    end
end

// ==============================
// Execute
// ==============================

// Load data beats execute result
always_comb begin : comb_exe_operands
    for (int i = 0; i < OPND_N; i++) begin
        if (dcd_ovr_q[i]) begin
            exe_val[i] = i_data_rd_data;
        end else if (dcd_fwd_q[i]) begin
            exe_val[i] = exe_result_q;
        end else begin
            exe_val[i] = dcd_val_q[i];
        end
    end
end

// TRUTH picks one bit per source
assign exe_truth_sel = {
    exe_val[2][dcd_instr_q.truth.mux_2],
    exe_val[1][dcd_instr_q.truth.mux_1],
    exe_val[0][dcd_instr_q.truth.mux_0]
};
assign exe_result_truth = {exe_val[OPND_7][6:0], dcd_instr_q.truth.lut[exe_truth_sel]};

// SHUFFLE
assign exe_result_shuffle[0] = exe_val[0][dcd_instr_q.shuffle.mux_0];
assign exe_result_shuffle[1] = exe_val[0][dcd_instr_q.shuffle.mux_1];
assign exe_result_shuffle[2] = exe_val[0][dcd_instr_q.shuffle.mux_2];
assign exe_result_shuffle[3] = exe_val[0][dcd_instr_q.shuffle.mux_3];
assign exe_result_shuffle[4] = exe_val[0][dcd_instr_q.shuffle.mux_4];
assign exe_result_shuffle[5] = exe_val[0][dcd_instr_q.shuffle.mux_5];
assign exe_result_shuffle[6] = exe_val[0][dcd_instr_q.shuffle.mux_6];
assign exe_result_shuffle[7] = exe_val[0][dcd_instr_q.shuffle.mux_7];

assign exe_result = dcd_is_truth_q ? exe_result_truth : exe_result_shuffle;

// Data RAM access issued from execute
assign o_data_addr    = dcd_instr_q.memory.address;
assign o_data_rd_en   = dcd_is_load_q && !stall;
assign o_data_wr_en   = dcd_is_store_q && !stall;
assign o_data_wr_data = exe_val[0];

always_comb begin : comb_exe_message
    exe_message.target  = dcd_instr_q.memory.send_tgt;
    exe_message.address = dcd_instr_q.memory.address;
    exe_message.data    = exe_val[0];
end

// ==============================
// Commit
// ==============================

always_ff @(posedge i_clk) begin : ff_commit_ctrl
    if (i_reset) begin
        exe_cmt_ld_q  <= 1'b0;
        exe_cmt_res_q <= 1'b0;
        send_valid_q  <= 1'b0;
    end else if (!stall) begin
        exe_cmt_ld_q  <= dcd_is_load_q;
        exe_cmt_res_q <= dcd_is_truth_q || dcd_is_shuffle_q;
        // Previous message has gone out if not stalled
        send_valid_q  <= dcd_is_send_q;
    end
end

always_ff @(posedge i_clk) begin : ff_commit_data
    if (!stall) begin
        exe_tgt_q    <= dcd_tgt_q;
        exe_result_q <= exe_result;
        // Message held under back-pressure
        if (dcd_is_send_q) begin
            send_data_q <= exe_message;
        end
    end
end

assign o_send_data  = send_data_q;
assign o_send_valid = send_valid_q;

// Repeated writes while stalled carry the same value
always_ff @(posedge i_clk) begin : ff_regfile
    if (i_reset) begin
        for (int i = 0; i < `NODE_REG_COUNT; i++) begin
            regfile_q[i] <= '0;
        end
    end else if (cmt_valid) begin
        regfile_q[exe_tgt_q] <= cmt_value;
    end
end

endmodule

`default_nettype wire

/* verilog/node_defines.svh */
`ifndef NODE_DEFINES_SVH
`define NODE_DEFINES_SVH

// Instruction RAM address width
// 256 instruction slots
`define NODE_INST_ADDR_W 8

// Data RAM byte address width
// 256 bytes
`define NODE_DATA_ADDR_W 8

// Register file depth
// R7 doubles as the TRUTH accumulator
`define NODE_REG_COUNT 8

// Instruction word width
`define NODE_INST_W 32

`endif

/* verilog/node_pkg.sv */
`default_nettype none

`include "node_defines.svh"

package node_pkg;

// ==============================
// Encodings
// ==============================

typedef enum logic [1:0] {
    OP_PAUSE   = 2'd0,
    OP_TRUTH   = 2'd1,
    OP_SHUFFLE = 2'd2,
    OP_MEMORY  = 2'd3
} opcode_t;

// Modes of the memory operation
typedef enum logic [1:0] {
    MEM_LOAD  = 2'd0,
    MEM_STORE = 2'd1,
    MEM_SEND  = 2'd2
} mem_mode_t;

typedef logic [$clog2(`NODE_REG_COUNT)-1:0] reg_idx_t;

// ==============================
// Messages
// ==============================

typedef struct packed {
    logic [3:0] row;
    logic [3:0] column;
} node_id_t;

typedef struct packed {
    node_id_t                    target;
    logic [`NODE_DATA_ADDR_W-1:0] address;
    logic [7:0]                  data;
} node_message_t;

// ==============================
// Instruction views
// ==============================

// Opcode always in the top two bits
typedef struct packed {
    opcode_t                op;
    logic                   idle;
    logic                   pc0;
    logic [`NODE_INST_W-5:0] padding;
} inst_pause_t;

// Three bit picks index the lookup table
typedef struct packed {
    opcode_t                 op;
    reg_idx_t                src_a;
    reg_idx_t                src_b;
    reg_idx_t                src_c;
    logic [2:0]              mux_0;
    logic [2:0]              mux_1;
    logic [2:0]              mux_2;
    logic [7:0]              lut;
    logic [`NODE_INST_W-29:0] padding;
} inst_truth_t;

// Output bit N taken from source bit mux_N
typedef struct packed {
    opcode_t    op;
    reg_idx_t   src;
    reg_idx_t   tgt;
    logic [2:0] mux_0;
    logic [2:0] mux_1;
    logic [2:0] mux_2;
    logic [2:0] mux_3;
    logic [2:0] mux_4;
    logic [2:0] mux_5;
    logic [2:0] mux_6;
    logic [2:0] mux_7;
} inst_shuffle_t;

// reg_sel is the target for LOAD and the source for STORE and SEND
typedef struct packed {
    opcode_t                      op;
    mem_mode_t                    mode;
    reg_idx_t                     reg_sel;
    logic [`NODE_DATA_ADDR_W-1:0] address;
    node_id_t                     send_tgt;
    logic [`NODE_INST_W-24:0]     padding;
} inst_memory_t;

typedef union packed {
    inst_pause_t   pause;
    inst_truth_t   truth;
    inst_shuffle_t shuffle;
    inst_memory_t  memory;
} instruction_t;

endpackage

`default_nettype wire

/* verilog/node_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module node_ram #(
    parameter type ram_word_t = logic [7:0],
    parameter int  ADDR_W     = 8
) (
    input  wire              i_clk,
    input  wire              i_reset,
    // Write port
    input  wire              i_wr_en,
    input  wire [ADDR_W-1:0] i_wr_addr,
    input  wire ram_word_t   i_wr_data,
    // Read port
    input  wire              i_rd_en,
    input  wire [ADDR_W-1:0] i_rd_addr,
    output ram_word_t        o_rd_data
);

localparam int DEPTH = 1 << ADDR_W;

ram_word_t mem_q [DEPTH];

// Write lands on the clock edge
always_ff @(posedge i_clk) begin : ff_write
    if (i_wr_en) begin
        mem_q[i_wr_addr] <= i_wr_data;
    end
end

// Read data appears next cycle
// Output holds while no read is enabled
always_ff @(posedge i_clk) begin : ff_read
    if (i_reset) begin
        o_rd_data <= '0;
    end else if (i_rd_en) begin
        o_rd_data <= mem_q[i_rd_addr];
    end
end

endmodule

`default_nettype wire

/* verilog/node_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "node_defines.svh"

module node_top (
    input  wire                          i_clk,
    input  wire                          i_reset,
    // Control
    input  wire                          i_trigger,
    output logic                         o_idle,
    // Instruction load, only while idle
    input  wire                          i_load_valid,
    input  wire [`NODE_INST_ADDR_W-1:0]  i_load_addr,
    input  wire node_pkg::instruction_t  i_load_data,
    // Outbound messages
    output node_pkg::node_message_t      o_send_data,
    output logic                         o_send_valid,
    input  wire                          i_send_ready
);

// ==============================
// Core to RAM wiring
// ==============================

logic [`NODE_INST_ADDR_W-1:0] inst_addr;
logic                         inst_rd_en;
node_pkg::instruction_t       inst_rd_data;
logic [`NODE_DATA_ADDR_W-1:0] data_addr;
logic                         data_rd_en;
logic                         data_wr_en;
logic [7:0]                   data_wr_data;
logic [7:0]                   data_rd_data;

node_core u_core (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_trigger      (i_trigger),
    .o_idle         (o_idle),
    .o_inst_addr    (inst_addr),
    .o_inst_rd_en   (inst_rd_en),
    .i_inst_rd_data (inst_rd_data),
    .o_data_addr    (data_addr),
    .o_data_rd_en   (data_rd_en),
    .o_data_wr_en   (data_wr_en),
    .o_data_wr_data (data_wr_data),
    .i_data_rd_data (data_rd_data),
    .o_send_data    (o_send_data),
    .o_send_valid   (o_send_valid),
    .i_send_ready   (i_send_ready)
);

// Instruction store, written by the load port
node_ram #(
    .ram_word_t (node_pkg::instruction_t),
    .ADDR_W     (`NODE_INST_ADDR_W)
) u_inst_ram (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_wr_en   (i_load_valid),
    .i_wr_addr (i_load_addr),
    .i_wr_data (i_load_data),
    .i_rd_en   (inst_rd_en),
    .i_rd_addr (inst_addr),
    .o_rd_data (inst_rd_data)
);

// Byte-wide data store
// One address shared by both ports
node_ram #(
    .ram_word_t (logic [7:0]),
    .ADDR_W     (`NODE_DATA_ADDR_W)
) u_data_ram (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_wr_en   (data_wr_en),
    .i_wr_addr (data_addr),
    .i_wr_data (data_wr_data),
    .i_rd_en   (data_rd_en),
    .i_rd_addr (data_addr),
    .o_rd_data (data_rd_data)
);

endmodule

`default_nettype wire
